//--- Makefile
# Verilator build and run of the miss unit testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tb_dcache_missunit
FILELIST ?= dcache_missunit.f
OBJ_DIR  ?= obj_dir
PASS_MSG := RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dcache_missunit.f
+incdir+logic
logic/missunit_pkg.sv
logic/miss_port_arbiter.sv
logic/mshr_ctrl.sv
logic/refill_writer.sv
logic/dcache_missunit.sv
sim/tb_clock_gen.sv
sim/tb_dcache_missunit.sv

//--- logic/dcache_missunit.sv
// L1 data cache miss unit
// Top of the miss handler: port arbiter, MSHR controller and refill writer
// sharing one memory request bus with a request/acknowledge handshake.

`timescale 1ns/1ps
`default_nettype none

`include "missunit_macros.svh"

module dcache_missunit (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    // miss ports
    input  logic [`MU_NUM_PORTS-1:0]                      miss_req_i,
    input  missunit_pkg::miss_req_t [`MU_NUM_PORTS-1:0]   miss_i,
    output logic [`MU_NUM_PORTS-1:0]                      miss_ack_o,
    output logic                                          miss_o,
    output logic [`MU_NUM_PORTS-1:0]                      miss_rtrn_vld_o,
    output missunit_pkg::tid_t                            miss_rtrn_id_o,
    // cache line write port
    output missunit_pkg::cl_wr_t                          cl_wr_o,
    // memory bus
    output logic                                          mem_req_o,
    input  logic                                          mem_ack_i,
    output missunit_pkg::mem_req_t                        mem_data_o,
    input  logic                                          mem_rtrn_vld_i,
    input  missunit_pkg::mem_rtrn_t                       mem_rtrn_i
);

    logic                    sel_valid, mask_reads, lock;
    missunit_pkg::port_idx_t sel_idx;
    missunit_pkg::miss_req_t sel_miss;
    missunit_pkg::req_type_e rtype;
    missunit_pkg::way_idx_t  repl_way;
    logic                    load_ack, mshr_vld;
    missunit_pkg::mshr_t     mshr;

    miss_port_arbiter i_arbiter (
        .clk_i, .rst_ni, .miss_req_i, .miss_i,
        .mask_reads_i ( mask_reads ),
        .lock_i       ( lock       ),
        .sel_valid_o  ( sel_valid  ),
        .sel_idx_o    ( sel_idx    ),
        .sel_miss_o   ( sel_miss   ),
        .rtype_i      ( rtype      ),
        .way_i        ( repl_way   ),
        .mem_data_o
    );

    mshr_ctrl i_mshr_ctrl (
        .clk_i, .rst_ni,
        .sel_valid_i  ( sel_valid  ),
        .sel_idx_i    ( sel_idx    ),
        .sel_miss_i   ( sel_miss   ),
        .mem_ack_i,
        .load_ack_i   ( load_ack   ),
        .mem_req_o, .miss_ack_o,
        .rtype_o      ( rtype      ),
        .way_o        ( repl_way   ),
        .mask_reads_o ( mask_reads ),
        .lock_o       ( lock       ),
        .mshr_o       ( mshr       ),
        .mshr_vld_o   ( mshr_vld   ),
        .miss_o
    );

    refill_writer i_refill_writer (
        .clk_i, .rst_ni, .mem_rtrn_vld_i, .mem_rtrn_i,
        .mshr_i       ( mshr       ),
        .mshr_vld_i   ( mshr_vld   ),
        .load_ack_o   ( load_ack   ),
        .miss_rtrn_vld_o, .miss_rtrn_id_o, .cl_wr_o
    );

endmodule

`default_nettype wire

//--- logic/miss_port_arbiter.sv
// Miss port arbiter
// Fixed-priority grant of one miss port, lowest index first. The grant is
// frozen while the controller locks it, and the granted port's fields are
// steered onto the memory request bus.

`timescale 1ns/1ps
`default_nettype none

`include "missunit_macros.svh"

module miss_port_arbiter (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic [`MU_NUM_PORTS-1:0]                      miss_req_i,
    input  missunit_pkg::miss_req_t [`MU_NUM_PORTS-1:0]   miss_i,
    input  logic                                          mask_reads_i,
    input  logic                                          lock_i,
    output logic                                          sel_valid_o,
    output missunit_pkg::port_idx_t                       sel_idx_o,
    output missunit_pkg::miss_req_t                       sel_miss_o,
    input  missunit_pkg::req_type_e                       rtype_i,
    input  missunit_pkg::way_idx_t                        way_i,
    output missunit_pkg::mem_req_t                        mem_data_o
);

    logic [`MU_NUM_PORTS-1:0] we_vec;
    logic [`MU_NUM_PORTS-1:0] req_masked_d, req_masked_q;

    always_comb begin : p_grant
        for (int k = 0; k < `MU_NUM_PORTS; k++) begin
            we_vec[k] = miss_i[k].we;
        end
        // keep last cycle's mask while a request is in flight
        if (lock_i) begin
            req_masked_d = req_masked_q;
        end else if (mask_reads_i) begin
            req_masked_d = miss_req_i & we_vec;
        end else begin
            req_masked_d = miss_req_i;
        end
        // scan downwards so the lowest request wins
        sel_idx_o = '0;
        for (int k = `MU_NUM_PORTS-1; k >= 0; k--) begin
            if (req_masked_d[k]) begin
                sel_idx_o = missunit_pkg::port_idx_t'(k);
            end
        end
    end

    assign sel_valid_o = |req_masked_d;
    assign sel_miss_o  = miss_i[sel_idx_o];

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_mask_reg
        if (!rst_ni) begin
            req_masked_q <= '0;
        end else begin
            req_masked_q <= req_masked_d;
        end
    end

    ////////////////////////////////////////
    // outgoing request bus
    ////////////////////////////////////////

    assign mem_data_o.rtype = rtype_i;
    assign mem_data_o.tid   = sel_miss_o.id;
    assign mem_data_o.nc    = sel_miss_o.nc;
    assign mem_data_o.way   = way_i;
    assign mem_data_o.paddr = sel_miss_o.paddr;
    assign mem_data_o.size  = sel_miss_o.size;
    assign mem_data_o.data  = sel_miss_o.wdata;

    // port roles, reads below the last port, writes on it
    read_ports_no_we : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (miss_req_i[`MU_NUM_PORTS-2:0] & we_vec[`MU_NUM_PORTS-2:0]) == '0)
        else $error("miss arbiter: read port issued a write");

    write_port_we : assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i[`MU_NUM_PORTS-1] |-> we_vec[`MU_NUM_PORTS-1])
        else $error("miss arbiter: write port issued a read");

endmodule

`default_nettype wire

//--- logic/missunit_macros.svh
// Miss unit width and count macros
// Shared sizing for the L1 data cache miss handler: ports, ways,
// address split, line and data widths, transaction ids

`ifndef MISSUNIT_MACROS_SVH
`define MISSUNIT_MACROS_SVH

// miss ports, the highest one carries writes only
`define MU_NUM_PORTS 3
// ways per set
`define MU_SET_ASSOC 4

// address split
`define MU_PADDR_W   32
`define MU_OFFSET_W  4
`define MU_INDEX_W   8

`define MU_LINE_W    128
`define MU_ID_W      2
`define MU_DATA_W    64

`endif

//--- logic/missunit_pkg.sv
// Miss unit package
// Vector types, bus structs and enums shared by the miss handler blocks

`default_nettype none

`include "missunit_macros.svh"

package missunit_pkg;

    typedef logic [`MU_PADDR_W-1:0]                   paddr_t;
    typedef logic [`MU_PADDR_W-`MU_INDEX_W-1:0]       tag_t;
    typedef logic [`MU_INDEX_W-`MU_OFFSET_W-1:0]      cl_idx_t;
    typedef logic [`MU_SET_ASSOC-1:0]                 way_vec_t;
    typedef logic [$clog2(`MU_SET_ASSOC)-1:0]         way_idx_t;
    typedef logic [$clog2(`MU_NUM_PORTS)-1:0]         port_idx_t;
    typedef logic [`MU_ID_W-1:0]                      tid_t;
    typedef logic [`MU_DATA_W-1:0]                    wdata_t;
    typedef logic [`MU_LINE_W-1:0]                    line_t;

    typedef enum logic {LOAD_REQ, STORE_REQ} req_type_e;

    typedef enum logic [1:0] {RTRN_LOAD_ACK, RTRN_STORE_ACK, RTRN_OTHER} rtrn_type_e;

    // one port's miss as seen by the handler
    typedef struct packed {
        paddr_t    paddr; logic we; logic nc; logic [2:0] size;
        tid_t      id; way_vec_t vld_bits; wdata_t wdata;
    } miss_req_t;

    // request bus towards memory
    typedef struct packed {
        req_type_e rtype; tid_t tid; logic nc; way_idx_t way;
        paddr_t    paddr; logic [2:0] size; wdata_t data;
    } mem_req_t;

    typedef struct packed {
        rtrn_type_e rtype; tid_t tid; logic nc; line_t data;
    } mem_rtrn_t;

    // the single outstanding read
    typedef struct packed {
        paddr_t paddr; tid_t id; logic nc; way_idx_t repl_way; port_idx_t port_idx;
    } mshr_t;

    // full line write into the data and tag arrays
    typedef struct packed {
        logic vld; logic nc; way_vec_t we; tag_t tag; cl_idx_t idx;
        logic [`MU_OFFSET_W-1:0] off; line_t data;
        logic [`MU_LINE_W/8-1:0] data_be; way_vec_t vld_bits;
    } cl_wr_t;

endpackage

`default_nettype wire

//--- logic/mshr_ctrl.sv
// MSHR controller
// Issues the granted miss on the memory bus and waits for its acknowledge.
// Writes pass through unless they hit the outstanding read's line; a read
// allocates the single MSHR and picks its replacement way, the lowest
// invalid way or a pseudo-random one from an 8-bit LFSR.

`timescale 1ns/1ps
`default_nettype none

`include "missunit_macros.svh"

module mshr_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            sel_valid_i,
    input  missunit_pkg::port_idx_t         sel_idx_i,
    input  missunit_pkg::miss_req_t         sel_miss_i,
    input  logic                            mem_ack_i,
    input  logic                            load_ack_i,
    output logic                            mem_req_o,
    output logic [`MU_NUM_PORTS-1:0]        miss_ack_o,
    output missunit_pkg::req_type_e         rtype_o,
    output missunit_pkg::way_idx_t          way_o,
    output logic                            mask_reads_o,
    output logic                            lock_o,
    output missunit_pkg::mshr_t             mshr_o,
    output logic                            mshr_vld_o,
    output logic                            miss_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_STORE_WAIT, ST_LOAD_WAIT} state_e;

    state_e                 state_d, state_q;
    missunit_pkg::mshr_t    mshr_q;
    logic                   mshr_vld_d, mshr_vld_q;
    logic                   mshr_alloc, update_lfsr;
    logic                   wr_collision, all_ways_valid;
    missunit_pkg::way_idx_t inv_way, rnd_way, repl_way;
    logic [7:0]             lfsr_q;

    ////////////////////////////////////////
    // replacement way
    ////////////////////////////////////////

    always_comb begin : p_inv_way
        inv_way = '0;
        for (int k = `MU_SET_ASSOC-1; k >= 0; k--) begin
            if (!sel_miss_i.vld_bits[k]) begin
                inv_way = missunit_pkg::way_idx_t'(k);
            end
        end
    end

    assign all_ways_valid = &sel_miss_i.vld_bits;
    assign rnd_way        = lfsr_q[$clog2(`MU_SET_ASSOC)-1:0];
    assign repl_way       = all_ways_valid ? rnd_way : inv_way;
    assign way_o          = repl_way;

    // write to the line that is being refilled must wait
    assign wr_collision = mshr_vld_q &&
        (mshr_q.paddr[`MU_PADDR_W-1:`MU_OFFSET_W] == sel_miss_i.paddr[`MU_PADDR_W-1:`MU_OFFSET_W]);

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    always_comb begin : p_fsm
        state_d     = state_q;
        mem_req_o   = 1'b0;
        rtype_o     = missunit_pkg::LOAD_REQ;
        lock_o      = 1'b0;
        mshr_alloc  = 1'b0;
        update_lfsr = 1'b0;
        unique case (state_q)
            ST_IDLE: begin
                if (sel_valid_i && sel_miss_i.we) begin
                    if (!wr_collision) begin
                        mem_req_o = 1'b1;
                        rtype_o   = missunit_pkg::STORE_REQ;
                        if (!mem_ack_i) state_d = ST_STORE_WAIT;
                    end
                // a load ack in this cycle frees the MSHR
                end else if (sel_valid_i && (!mshr_vld_q || load_ack_i)) begin
                    mem_req_o   = 1'b1;
                    mshr_alloc  = mem_ack_i;
                    update_lfsr = mem_ack_i & all_ways_valid;
                    if (!mem_ack_i) state_d = ST_LOAD_WAIT;
                end
            end
            ST_STORE_WAIT: begin
                lock_o    = 1'b1;
                mem_req_o = 1'b1;
                rtype_o   = missunit_pkg::STORE_REQ;
                if (mem_ack_i) state_d = ST_IDLE;
            end
            ST_LOAD_WAIT: begin
                lock_o    = 1'b1;
                mem_req_o = 1'b1;
                if (mem_ack_i) begin
                    mshr_alloc  = 1'b1;
                    update_lfsr = all_ways_valid;
                    state_d     = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin : p_ack
        miss_ack_o            = '0;
        miss_ack_o[sel_idx_i] = mem_req_o & mem_ack_i;
    end

    assign mask_reads_o = mshr_vld_q & ~load_ack_i;
    assign mshr_vld_d   = mshr_alloc ? 1'b1 : (load_ack_i ? 1'b0 : mshr_vld_q);
    assign miss_o       = mshr_alloc & ~sel_miss_i.nc;
    assign mshr_o       = mshr_q;
    assign mshr_vld_o   = mshr_vld_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
        if (!rst_ni) begin
            state_q    <= ST_IDLE;
            mshr_vld_q <= 1'b0;
            lfsr_q     <= 8'h5a;
        end else begin
            state_q    <= state_d;
            mshr_vld_q <= mshr_vld_d;
            // taps 8,6,5,4
            if (update_lfsr) lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    always_ff @(posedge clk_i) begin : p_mshr
        if (mshr_alloc) begin
            mshr_q.paddr    <= sel_miss_i.paddr;
            mshr_q.id       <= sel_miss_i.id;
            mshr_q.nc       <= sel_miss_i.nc;
            mshr_q.repl_way <= repl_way;
            mshr_q.port_idx <= sel_idx_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/refill_writer.sv
// Refill writer
// Decodes memory responses into load and store acknowledges, signals the
// waiting port, and writes a cached refill line into its replacement way.

`timescale 1ns/1ps
`default_nettype none

`include "missunit_macros.svh"

module refill_writer (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        mem_rtrn_vld_i,
    input  missunit_pkg::mem_rtrn_t     mem_rtrn_i,
    input  missunit_pkg::mshr_t         mshr_i,
    input  logic                        mshr_vld_i,
    output logic                        load_ack_o,
    output logic [`MU_NUM_PORTS-1:0]    miss_rtrn_vld_o,
    output missunit_pkg::tid_t          miss_rtrn_id_o,
    output missunit_pkg::cl_wr_t        cl_wr_o
);

    logic                   store_ack;
    logic                   cl_write_en;
    missunit_pkg::way_vec_t repl_way_oh;

    assign load_ack_o = mem_rtrn_vld_i && (mem_rtrn_i.rtype == missunit_pkg::RTRN_LOAD_ACK);
    assign store_ack  = mem_rtrn_vld_i && (mem_rtrn_i.rtype == missunit_pkg::RTRN_STORE_ACK);

    always_comb begin : p_rtrn
        miss_rtrn_vld_o = '0;
        if (load_ack_o) miss_rtrn_vld_o[mshr_i.port_idx] = 1'b1;
        // stores only come from the last port
        if (store_ack) miss_rtrn_vld_o[`MU_NUM_PORTS-1] = 1'b1;
    end

    assign miss_rtrn_id_o = mem_rtrn_i.tid;

    ////////////////////////////////////////
    // line write
    ////////////////////////////////////////

    // uncached loads never touch the arrays
    assign cl_write_en = load_ack_o & ~mshr_i.nc;
    assign repl_way_oh = missunit_pkg::way_vec_t'(1) << mshr_i.repl_way;

    assign cl_wr_o.vld      = cl_write_en;
    assign cl_wr_o.nc       = mshr_i.nc;
    assign cl_wr_o.we       = cl_write_en ? repl_way_oh : '0;
    assign cl_wr_o.vld_bits = cl_write_en ? repl_way_oh : '0;
    assign cl_wr_o.tag      = mshr_i.paddr[`MU_PADDR_W-1:`MU_INDEX_W];
    assign cl_wr_o.idx      = mshr_i.paddr[`MU_INDEX_W-1:`MU_OFFSET_W];
    assign cl_wr_o.off      = mshr_i.paddr[`MU_OFFSET_W-1:0];
    assign cl_wr_o.data     = mem_rtrn_i.data;
    assign cl_wr_o.data_be  = cl_write_en ? '1 : '0;

    // a load ack must belong to the read held in the MSHR
    load_ack_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_ack_o |-> (mshr_vld_i && mem_rtrn_i.tid == mshr_i.id))
        else $error("refill writer: load ack without matching MSHR id");

endmodule

`default_nettype wire

//--- sim/missunit_tests.txt
# op port we nc addr vld id wdata delay rdata, all hex
# op 0 full miss, 1 raise, 2 serve, 3 respond, 4 bus idle for delay cycles; delay f is random
0 0 0 0 00001230 5 0 0 1 0123456789abcdef0011223344556677
0 1 0 0 0000a540 f 1 0 2 fedcba98765432100123456789abcdef
0 0 0 1 80000010 0 2 0 0 000000000000000000000000c0ffee00
0 2 1 0 00004418 0 3 1122334455667788 3 0
1 1 0 0 00002000 e 1 0 0 11111111222222223333333344444444
1 0 0 0 00003000 3 0 0 f 55555555666666667777777788888888
2 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 1 0 0 0
3 0 0 0 0 0 1 0 0 0
1 0 0 0 00005100 0 0 0 1 9999999999999999aaaaaaaaaaaaaaaa
2 0 0 0 0 0 0 0 0 0
1 2 1 0 00005108 0 1 00000000cafef00d 0 0
4 0 0 0 0 0 0 0 4 0
3 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 1 0 0 0
3 0 0 0 0 0 1 0 0 0
1 1 0 0 00006200 7 2 0 2 bbbbbbbbccccccccddddddddeeeeeeee
2 0 0 0 0 0 2 0 0 0
1 2 1 0 00007300 0 3 000000000000beef 1 0
2 0 0 0 0 0 3 0 0 0
3 0 0 0 0 0 3 0 0 0
3 0 0 0 0 0 2 0 0 0

//--- sim/tb_clock_gen.sv
// Testbench clock and reset
// 8 ns clock, reset held low for the first two cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_dcache_missunit.sv
// Miss unit testbench
// Replays vectors from the tests file: raises port requests, acts as the
// memory with a programmable acknowledge delay, returns load and store
// acknowledges, and checks bus fields, port acknowledges and line writes.

`timescale 1ns/1ps
`default_nettype none

`include "missunit_macros.svh"

module tb_dcache_missunit;

    localparam int TIMEOUT = 50;

    logic                                        clk, rst_n;
    logic [`MU_NUM_PORTS-1:0]                    miss_req, miss_ack, miss_rtrn_vld;
    missunit_pkg::miss_req_t [`MU_NUM_PORTS-1:0] miss;
    logic                                        miss_pulse, mem_req, mem_ack, mem_rtrn_vld;
    missunit_pkg::tid_t                          rtrn_id;
    missunit_pkg::cl_wr_t                        cl_wr;
    missunit_pkg::mem_req_t                      mem_data;
    missunit_pkg::mem_rtrn_t                     mem_rtrn;

    // vectors indexed by transaction id
    missunit_pkg::miss_req_t vec_req [4];
    missunit_pkg::line_t     vec_line [4];
    int                      vec_port [4];
    int                      vec_delay [4];

    int         checks = 0;
    int         errors = 0;
    int         aborts = 0;
    logic [7:0] lfsr_state = 8'd9;

    tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

    dcache_missunit UUT (
        .clk_i(clk), .rst_ni(rst_n),
        .miss_req_i(miss_req), .miss_i(miss), .miss_ack_o(miss_ack), .miss_o(miss_pulse),
        .miss_rtrn_vld_o(miss_rtrn_vld), .miss_rtrn_id_o(rtrn_id), .cl_wr_o(cl_wr),
        .mem_req_o(mem_req), .mem_ack_i(mem_ack), .mem_data_o(mem_data),
        .mem_rtrn_vld_i(mem_rtrn_vld), .mem_rtrn_i(mem_rtrn)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_value(input string what, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // fibonacci LFSR, one step per bit taken
    function automatic logic [3:0] take_bits(input int count);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r = {r[2:0], lfsr_state[0]};
            lfsr_state = {lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[4],
                          lfsr_state[7:1]};
        end
        return r;
    endfunction

    // one-hot of the lowest clear bit
    function automatic logic [`MU_SET_ASSOC-1:0] lowest_invalid(
        input logic [`MU_SET_ASSOC-1:0] vld);
        return ~vld & (vld + 1'b1);
    endfunction

    task automatic raise_request(input int id);
        miss[vec_port[id]]     = vec_req[id];
        miss_req[vec_port[id]] = 1'b1;
    endtask

    // memory side of one request: wait, hold off, acknowledge
    task automatic serve_request(input int id);
        missunit_pkg::mem_req_t snap;
        int n;
        int delay;
        n = 0;
        #2;
        while (mem_req !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (mem_req !== 1'b1) begin
            $display("timeout: transaction %0d never reached the memory bus", id);
            aborts++;
            return;
        end
        compare_value("request type", mem_data.rtype,
                      vec_req[id].we ? missunit_pkg::STORE_REQ : missunit_pkg::LOAD_REQ);
        compare_value("request tid", mem_data.tid, vec_req[id].id);
        compare_value("request paddr", mem_data.paddr, vec_req[id].paddr);
        compare_value("request nc", mem_data.nc, vec_req[id].nc);
        if (vec_req[id].we) compare_value("store data", mem_data.data, vec_req[id].wdata);
        snap  = mem_data;
        delay = (vec_delay[id] == 15) ? int'(take_bits(3)) : vec_delay[id];
        for (int d = 0; d < delay; d++) begin
            @(negedge clk);
            #2;
            compare_value("held request", {mem_req, mem_data}, {1'b1, snap});
        end
        @(negedge clk);
        mem_ack = 1'b1;
        #2;
        compare_value("request at acknowledge", {mem_req, mem_data}, {1'b1, snap});
        compare_value("port acknowledge", miss_ack, 1 << vec_port[id]);
        compare_value("miss pulse", miss_pulse, !vec_req[id].we && !vec_req[id].nc);
        @(negedge clk);
        mem_ack                = 1'b0;
        miss_req[vec_port[id]] = 1'b0;
    endtask

    task automatic send_response(input int id);
        logic cached_load;
        cached_load    = !vec_req[id].we && !vec_req[id].nc;
        mem_rtrn_vld   = 1'b1;
        mem_rtrn.rtype = vec_req[id].we ? missunit_pkg::RTRN_STORE_ACK
                                        : missunit_pkg::RTRN_LOAD_ACK;
        mem_rtrn.tid   = vec_req[id].id;
        mem_rtrn.nc    = vec_req[id].nc;
        mem_rtrn.data  = vec_line[id];
        #2;
        compare_value("return valid", miss_rtrn_vld, 1 << vec_port[id]);
        compare_value("return id", rtrn_id, vec_req[id].id);
        compare_value("line write valid", cl_wr.vld, cached_load);
        if (cached_load) begin
            if (&vec_req[id].vld_bits) begin
                compare_value("one-hot way", $countones(cl_wr.we), 1);
            end else begin
                compare_value("refill way", cl_wr.we, lowest_invalid(vec_req[id].vld_bits));
                compare_value("refill valid bits", cl_wr.vld_bits,
                              lowest_invalid(vec_req[id].vld_bits));
            end
            compare_value("refill tag", cl_wr.tag, vec_req[id].paddr[`MU_PADDR_W-1:`MU_INDEX_W]);
            compare_value("refill index", cl_wr.idx,
                          vec_req[id].paddr[`MU_INDEX_W-1:`MU_OFFSET_W]);
            compare_value("refill data", cl_wr.data, vec_line[id]);
            compare_value("refill byte enables", cl_wr.data_be, {(`MU_LINE_W/8){1'b1}});
        end
        @(negedge clk);
        mem_rtrn_vld = 1'b0;
    endtask

    task automatic expect_bus_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            #2;
            compare_value("stalled bus", mem_req, 1'b0);
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////
    // vector replay
    ////////////////////////////////////////

    initial begin : p_main
        int          fd, n, op, port, we, nc, vld, id, delay;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [127:0] rdata;
        string       line;
        miss_req     = '0;
        miss         = '0;
        mem_ack      = 1'b0;
        mem_rtrn_vld = 1'b0;
        mem_rtrn     = '0;
        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            aborts++;
        end
        #2;
        compare_value("outputs after reset", {mem_req, miss_ack, miss_rtrn_vld, cl_wr.vld}, 0);
        @(negedge clk);
        fd = $fopen("sim/missunit_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            aborts++;
        end
        while (fd != 0 && aborts == 0 && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        op, port, we, nc, addr, vld, id, wdata, delay, rdata);
            if (n != 10) begin
                $display("malformed test vector line: %s", line);
                aborts++;
            end else begin
                if (op <= 1) begin
                    vec_port[id]  = port;
                    vec_delay[id] = delay;
                    vec_line[id]  = rdata;
                    vec_req[id]   = '{paddr: addr, we: we[0], nc: nc[0], size: 3'd3,
                                      id: missunit_pkg::tid_t'(id),
                                      vld_bits: vld[`MU_SET_ASSOC-1:0], wdata: wdata};
                end
                case (op)
                    0: begin
                        raise_request(id);
                        serve_request(id);
                        if (aborts == 0) send_response(id);
                    end
                    1: raise_request(id);
                    2: serve_request(id);
                    3: send_response(id);
                    4: expect_bus_idle(delay);
                    default: begin
                        $display("unknown operation %0d in test vectors", op);
                        aborts++;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        $display("checks %0d, errors %0d, aborts %0d", checks, errors, aborts);
        if (errors == 0 && aborts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
